/* common/mipsPkg.sv */
package mipsPkg;

	////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////
	localparam int dataWidth     = 32;
	localparam int regAddrWidth  = 5;
	localparam int regCount      = 1 << regAddrWidth;
	localparam int imemWords     = 64;
	localparam int dmemWords     = 64;
	localparam int imemAddrWidth = $clog2(imemWords);
	localparam int dmemAddrWidth = $clog2(dmemWords);

	typedef logic [dataWidth-1:0]    wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////
	typedef enum logic [5:0] {
		opRFormat = 6'h00,
		opAddi    = 6'h08,
		opLw      = 6'h23,
		opSw      = 6'h2B
	} opcodeE;

	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2A
	} functE;

	typedef enum logic [2:0] {
		aluNone = 3'd0, // Zeroed controls decode as none
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluOr   = 3'd4,
		aluSlt  = 3'd5
	} aluOpE;

	typedef enum logic [1:0] {
		fromRegFile   = 2'd0,
		fromWriteback = 2'd1,
		fromMemStage  = 2'd2
	} fwdSelE;

	////////////////////////////////////////
	// Stage contents
	////////////////////////////////////////
	typedef struct packed {
		logic  regWrite;
		logic  memToReg;
		logic  memRead;
		logic  memWrite;
		logic  aluSrc;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		regAddrT rsId;
		regAddrT rtId;
	} srcRegsT;

	typedef struct packed {
		ctrlT    ctrl;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
		wordT    readData1;
		wordT    readData2;
		wordT    imm;
	} idExT;

	typedef struct packed {
		logic    regWrite;
		logic    memToReg;
		logic    memRead;
		logic    memWrite;
		regAddrT dest;
		wordT    aluResult;
		wordT    storeData;
	} exMemT;

	typedef struct packed {
		logic    valid;
		regAddrT addr;
		wordT    data;
	} wbT;

endpackage

/* fetch/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
	input  logic          CLK,
	input  logic          RST,
	input  logic          stall,
	output mipsPkg::wordT pc,
	output mipsPkg::wordT instr
);

	mipsPkg::wordT                      rom [mipsPkg::imemWords];
	logic [mipsPkg::imemAddrWidth-1:0]  romIdx;
	mipsPkg::wordT                      romWord;
	mipsPkg::wordT                      pcNext;

	initial begin
		$readmemh("program.hex", rom);
	end

	assign romIdx  = pc[mipsPkg::imemAddrWidth+1:2]; // Word address
	assign romWord = rom[romIdx];
	assign pcNext  = pc + mipsPkg::wordT'(4);

	////////////////////////////////////////
	// PC and fetch/decode register
	////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			instr <= '0;
		end else if (!stall) begin
			instr <= romWord; // Held while decode waits on a load
		end
	end

endmodule

/* decode/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic              CLK,
	input  logic              RST,
	input  mipsPkg::wordT     instr,
	input  logic              stall,
	input  mipsPkg::wbT       wb,
	output mipsPkg::srcRegsT  srcRegs,
	output mipsPkg::idExT     idEx
);

	mipsPkg::wordT    regFile [mipsPkg::regCount];
	mipsPkg::ctrlT    ctrl;
	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::regAddrT rd;
	mipsPkg::regAddrT dest;
	mipsPkg::wordT    readData1;
	mipsPkg::wordT    readData2;
	mipsPkg::wordT    imm;
	logic             isRFormat;

	assign rs        = instr[25:21];
	assign rt        = instr[20:16];
	assign rd        = instr[15:11];
	assign isRFormat = (instr[31:26] == mipsPkg::opRFormat);
	assign dest      = isRFormat ? rd : rt;
	assign imm       = {{16{instr[15]}}, instr[15:0]};

	assign srcRegs.rsId = rs;
	assign srcRegs.rtId = rt;

	////////////////////////////////////////
	// Decoder
	////////////////////////////////////////
	always_comb begin
		ctrl = '0;
		case (mipsPkg::opcodeE'(instr[31:26]))
			mipsPkg::opRFormat: begin
				ctrl.regWrite = 1'b1;
				case (mipsPkg::functE'(instr[5:0]))
					mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:  ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					default:        ctrl.regWrite = 1'b0; // Unsupported funct
				endcase
			end
			mipsPkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = mipsPkg::aluAdd;
			end
			mipsPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = mipsPkg::aluAdd; // Address calc
			end
			mipsPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = mipsPkg::aluAdd;
			end
			default: ctrl = '0;
		endcase
	end

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////
	always_ff @(negedge CLK or posedge RST) begin
		if (RST) begin
			for (int i = 0; i < mipsPkg::regCount; i++) begin
				regFile[i] <= '0;
			end
		end else if (wb.valid) begin
			regFile[wb.addr] <= wb.data; // Falling edge so decode sees it this cycle
		end
	end

	assign readData1 = (rs == '0) ? '0 : regFile[rs];
	assign readData2 = (rt == '0) ? '0 : regFile[rt];

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			idEx <= '0;
		end else begin
			idEx.ctrl      <= stall ? '0 : ctrl; // Bubble
			idEx.rs        <= rs;
			idEx.rt        <= rt;
			idEx.dest      <= dest;
			idEx.readData1 <= readData1;
			idEx.readData2 <= readData2;
			idEx.imm       <= imm;
		end
	end

endmodule

/* execute/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic            CLK,
	input  logic            RST,
	input  mipsPkg::idExT   idEx,
	input  mipsPkg::fwdSelE fwdA,
	input  mipsPkg::fwdSelE fwdB,
	input  mipsPkg::wbT     wb,
	output mipsPkg::exMemT  exMem
);

	mipsPkg::wordT opA;
	mipsPkg::wordT opB;
	mipsPkg::wordT aluIn2;
	mipsPkg::wordT aluResult;

	// Operand source per forward select
	function automatic mipsPkg::wordT pickOperand(
		input mipsPkg::fwdSelE sel,
		input mipsPkg::wordT   regVal,
		input mipsPkg::wordT   wbVal,
		input mipsPkg::wordT   memVal
	);
		mipsPkg::wordT result;
		case (sel)
			mipsPkg::fromMemStage:  result = memVal;
			mipsPkg::fromWriteback: result = wbVal;
			default:                result = regVal;
		endcase
		return result;
	endfunction

	////////////////////////////////////////
	// Operand select
	////////////////////////////////////////
	assign opA    = pickOperand(fwdA, idEx.readData1, wb.data, exMem.aluResult);
	assign opB    = pickOperand(fwdB, idEx.readData2, wb.data, exMem.aluResult);
	assign aluIn2 = idEx.ctrl.aluSrc ? idEx.imm : opB;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (idEx.ctrl.aluOp)
			mipsPkg::aluAdd: aluResult = opA + aluIn2;
			mipsPkg::aluSub: aluResult = opA - aluIn2;
			mipsPkg::aluAnd: aluResult = opA & aluIn2;
			mipsPkg::aluOr:  aluResult = opA | aluIn2;
			mipsPkg::aluSlt: aluResult = mipsPkg::wordT'($signed(opA) < $signed(aluIn2));
			default:         aluResult = '0;
		endcase
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			exMem <= '0;
		end else begin
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.memToReg  <= idEx.ctrl.memToReg;
			exMem.memRead   <= idEx.ctrl.memRead;
			exMem.memWrite  <= idEx.ctrl.memWrite;
			exMem.dest      <= idEx.dest;
			exMem.aluResult <= aluResult;
			exMem.storeData <= opB; // Forwarded rt value for sw
		end
	end

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	input  mipsPkg::regAddrT rsId,
	input  mipsPkg::regAddrT rtId,
	input  mipsPkg::idExT    idEx,
	input  mipsPkg::exMemT   exMem,
	input  mipsPkg::wbT      wb,
	output logic             stall,
	output mipsPkg::fwdSelE  fwdA,
	output mipsPkg::fwdSelE  fwdB
);

	logic memWritesReg;

	assign memWritesReg = exMem.regWrite && (exMem.dest != '0);

	// Newest producer wins
	function automatic mipsPkg::fwdSelE pickForward(
		input mipsPkg::regAddrT src,
		input logic             memHit,
		input mipsPkg::regAddrT memDest,
		input mipsPkg::wbT      wbPort
	);
		mipsPkg::fwdSelE sel;
		if (memHit && (memDest == src)) begin
			sel = mipsPkg::fromMemStage;
		end else if (wbPort.valid && (wbPort.addr == src)) begin
			sel = mipsPkg::fromWriteback;
		end else begin
			sel = mipsPkg::fromRegFile;
		end
		return sel;
	endfunction

	assign fwdA = pickForward(idEx.rs, memWritesReg, exMem.dest, wb);
	assign fwdB = pickForward(idEx.rt, memWritesReg, exMem.dest, wb);

	// Load in execute feeding the instruction in decode
	assign stall = idEx.ctrl.memRead && ((idEx.rt == rsId) || (idEx.rt == rtId));

endmodule

/* verilog/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage (
	input  logic           CLK,
	input  logic           RST,
	input  mipsPkg::exMemT exMem,
	output mipsPkg::wbT    wb
);

	mipsPkg::wordT                     dmem [mipsPkg::dmemWords];
	logic [mipsPkg::dmemAddrWidth-1:0] memIdx;
	mipsPkg::wordT                     loadData;
	logic                              wbValid;
	logic                              wbMemToReg;
	mipsPkg::regAddrT                  wbAddr;
	mipsPkg::wordT                     wbAluResult;
	mipsPkg::wordT                     wbLoadData;

	assign memIdx   = exMem.aluResult[mipsPkg::dmemAddrWidth+1:2]; // Word index
	assign loadData = exMem.memRead ? dmem[memIdx] : '0;

	////////////////////////////////////////
	// Data memory
	////////////////////////////////////////
	always_ff @(negedge CLK or posedge RST) begin
		if (RST) begin
			for (int i = 0; i < mipsPkg::dmemWords; i++) begin
				dmem[i] <= '0;
			end
		end else if (exMem.memWrite) begin
			dmem[memIdx] <= exMem.storeData;
		end
	end

	////////////////////////////////////////
	// Memory/writeback register
	////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wbValid     <= 1'b0;
			wbMemToReg  <= 1'b0;
			wbAddr      <= '0;
			wbAluResult <= '0;
			wbLoadData  <= '0;
		end else begin
			wbValid     <= exMem.regWrite && (exMem.dest != '0); // r0 never strobes
			wbMemToReg  <= exMem.memToReg;
			wbAddr      <= exMem.dest;
			wbAluResult <= exMem.aluResult;
			wbLoadData  <= loadData;
		end
	end

	assign wb.valid = wbValid;
	assign wb.addr  = wbAddr;
	assign wb.data  = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
	input  logic          CLK,
	input  logic          RST,
	output mipsPkg::wordT pc,
	output mipsPkg::wbT   wb
);

	mipsPkg::wordT    instr;
	mipsPkg::srcRegsT srcRegs;
	mipsPkg::idExT    idEx;
	mipsPkg::exMemT   exMem;
	logic             stall;
	mipsPkg::fwdSelE  fwdA;
	mipsPkg::fwdSelE  fwdB;

	////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////
	fetchStage i_fetch (
		.CLK   (CLK),
		.RST   (RST),
		.stall (stall),
		.pc    (pc),
		.instr (instr)
	);

	decodeStage i_decode (
		.CLK     (CLK),
		.RST     (RST),
		.instr   (instr),
		.stall   (stall),
		.wb      (wb),
		.srcRegs (srcRegs),
		.idEx    (idEx)
	);

	executeStage i_execute (
		.CLK   (CLK),
		.RST   (RST),
		.idEx  (idEx),
		.fwdA  (fwdA),
		.fwdB  (fwdB),
		.wb    (wb),
		.exMem (exMem)
	);

	memoryStage i_memory (
		.CLK   (CLK),
		.RST   (RST),
		.exMem (exMem),
		.wb    (wb)
	);

	hazardUnit i_hazard (
		.rsId  (srcRegs.rsId),
		.rtId  (srcRegs.rtId),
		.idEx  (idEx),
		.exMem (exMem),
		.wb    (wb),
		.stall (stall),
		.fwdA  (fwdA),
		.fwdB  (fwdB)
	);

endmodule

/* testbench/mipsCore_checker.sv */
`timescale 1ns/1ps

module mipsCore_checker (
	input logic          CLK,
	input logic          RST,
	input mipsPkg::wordT pc,
	input logic          stall,
	input mipsPkg::wbT   wb
);

	int errorCount = 0; // Failed assertions so far

	////////////////////////////////////////
	// Program counter
	////////////////////////////////////////
	property pcStepsOrHolds;
		@(posedge CLK) disable iff (RST)
		!$past(RST) |-> (pc == $past(pc) + 32'd4) || ($past(stall) && (pc == $past(pc)));
	endproperty

	////////////////////////////////////////
	// Stall and writeback
	////////////////////////////////////////
	property stallSingleCycle;
		@(posedge CLK) disable iff (RST)
		stall |=> !stall; // Bubble covers a load-use gap in one cycle
	endproperty

	property wbNeverToZero;
		@(posedge CLK) disable iff (RST)
		wb.valid |-> (wb.addr != '0);
	endproperty

	property wbQuietAfterReset;
		@(posedge CLK) disable iff (RST)
		$past(RST) |-> !wb.valid;
	endproperty

	assert property (pcStepsOrHolds) else begin
		errorCount++;
		$error("PC neither stepped by 4 nor held for a stall");
	end

	assert property (stallSingleCycle) else begin
		errorCount++;
		$error("Stall held for two consecutive cycles");
	end

	assert property (wbNeverToZero) else begin
		errorCount++;
		$error("Writeback strobe with register 0 as destination");
	end

	assert property (wbQuietAfterReset) else begin
		errorCount++;
		$error("Writeback strobe right after reset");
	end

endmodule

bind mipsCore mipsCore_checker i_checker (
	.CLK   (CLK),
	.RST   (RST),
	.pc    (pc),
	.stall (stall),
	.wb    (wb)
);

/* testbench/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int clkPeriod    = 20;
	localparam int resetCycles  = 3;
	localparam int progWords    = 14; // Instructions ahead of the zero words
	localparam int pipeDepth    = 5;
	localparam int loadStalls   = 1;
	localparam int drainCycles  = 5; // Lets the trailing zero words retire
	localparam int marginCycles = 32;
	localparam int watchdogCycles = resetCycles + progWords + pipeDepth + loadStalls
		+ drainCycles + marginCycles;

	logic          CLK;
	logic          RST;
	mipsPkg::wordT pc;
	mipsPkg::wbT   wb;

	mipsPkg::wbT expectQ [$];
	int          stallCycles = 0;

	mipsCore i_dut (
		.CLK (CLK),
		.RST (RST),
		.pc  (pc),
		.wb  (wb)
	);

	function automatic mipsPkg::wbT expectedWrite(input int addr, input mipsPkg::wordT data);
		mipsPkg::wbT entry;
		entry.valid = 1'b1;
		entry.addr  = mipsPkg::regAddrT'(addr);
		entry.data  = data;
		return entry;
	endfunction

	// Register results of program.hex in retire order
	task automatic loadExpected();
		expectQ.push_back(expectedWrite(1, 32'd5));
		expectQ.push_back(expectedWrite(2, 32'hFFFF_FFFD));  // -3
		expectQ.push_back(expectedWrite(3, 32'd12));
		expectQ.push_back(expectedWrite(4, 32'd17));         // 5 + 12
		expectQ.push_back(expectedWrite(5, 32'd20));         // 17 - (-3)
		expectQ.push_back(expectedWrite(6, 32'h0000_0010));  // 0x11 & 0x14
		expectQ.push_back(expectedWrite(7, 32'h0000_0015));  // 0x10 | 0x05
		expectQ.push_back(expectedWrite(8, 32'd21));         // Load of the stored word
		expectQ.push_back(expectedWrite(9, 32'd26));         // 21 + 5 after the stall
		expectQ.push_back(expectedWrite(10, 32'd1));         // -3 < 5 signed
		expectQ.push_back(expectedWrite(11, 32'd1));         // 1 < 26
		expectQ.push_back(expectedWrite(12, 32'd17));        // r0 still reads zero
	endtask

	task automatic stopWithFailure();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	////////////////////////////////////////
	// Writeback and checker monitors
	////////////////////////////////////////
	always @(negedge CLK) begin
		if (!RST && wb.valid) begin
			assert (expectQ.size() != 0) begin
				assert (wb === expectQ[0]) begin
					void'(expectQ.pop_front());
				end else begin
					$display("** Error at %0t ns: r%0d written 0x%08h, expected r%0d = 0x%08h",
						$time, wb.addr, wb.data, expectQ[0].addr, expectQ[0].data);
					stopWithFailure();
				end
			end else begin
				$display("Unexpected write to r%0d at %0t ns after the last expected result",
					wb.addr, $time);
				stopWithFailure();
			end
		end
	end

	always @(negedge CLK) begin
		if (!RST && i_dut.stall) begin
			stallCycles++;
		end
	end

	always @(negedge CLK) begin
		assert (i_dut.i_checker.errorCount == 0) else begin
			$display("A pipeline assertion in the bound checker failed before %0t ns", $time);
			stopWithFailure();
		end
	end

	////////////////////////////////////////
	// Reset and end of run
	////////////////////////////////////////
	initial begin
		RST = 1'b1;
		loadExpected();
		repeat (resetCycles) @(posedge CLK);
		#2;
		RST = 1'b0;
		assert (pc == '0) else begin
			$display("** Error at %0t ns: PC is 0x%08h after reset, expected 0", $time, pc);
			stopWithFailure();
		end
		while (expectQ.size() != 0) @(posedge CLK);
		repeat (drainCycles) @(posedge CLK);
		if (stallCycles == loadStalls) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("** Error at %0t ns: %0d stall cycles seen, expected %0d",
				$time, stallCycles, loadStalls);
			stopWithFailure();
		end
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout after %0d cycles with %0d results still outstanding",
			watchdogCycles, expectQ.size());
		stopWithFailure();
	end

endmodule

/* program.hex */
// One 32-bit instruction word per line in hex, ROM word 0 first
20010005 // addi $1, $0, 5
2002FFFD // addi $2, $0, -3
2003000C // addi $3, $0, 12
00232020 // add  $4, $1, $3
00822822 // sub  $5, $4, $2
00853024 // and  $6, $4, $5
00C13825 // or   $7, $6, $1
AC070008 // sw   $7, 8($0)
8C080008 // lw   $8, 8($0)
01014820 // add  $9, $8, $1
0041502A // slt  $10, $2, $1
0149582A // slt  $11, $10, $9
20000007 // addi $0, $0, 7
00046020 // add  $12, $0, $4
00000000
00000000
00000000
00000000
00000000

/* project.f */
common/mipsPkg.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
verilog/hazardUnit.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
testbench/mipsCore_checker.sv
testbench/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - common/mipsPkg.sv
  - fetch/fetchStage.sv
  - decode/decodeStage.sv
  - execute/executeStage.sv
  - verilog/hazardUnit.sv
  - verilog/memoryStage.sv
  - verilog/mipsCore.sv
  - target: test
    files:
      - testbench/mipsCore_checker.sv
      - testbench/mipsCoreTb.sv
